//--- chip_pkg.sv
package chip_pkg;

  // data path widths
  localparam int WORD_W = 32;
  localparam int ANC_W = 2;

  // host FIFOs
  localparam int FIFO_DEPTH = 8;
  localparam int FIFO_AW = 3;

  // serial framing: start, 32 data bits LSB first, even parity, stop
  localparam int BIT_CYCLES = 4;
  localparam int BIT_CW = $clog2(BIT_CYCLES);
  localparam int FRAME_BITS = 35;
  localparam int IDX_W = $clog2(FRAME_BITS);

  // transmit compares the looped-back line two cycles into each bit
  localparam int TX_CHECK_CYC = BIT_CYCLES / 2;
  // receive sampling point, counted from the synchronized start edge
  localparam int RX_SAMPLE_CYC = BIT_CYCLES / 2 - 1;

  // core reset is released when the top counter bit sets
  localparam int RST_CNT_W = 6;

  // anc bit 0 is parity good, bit 1 is stop bit good
  typedef struct packed {
    logic [ANC_W-1:0]  anc;
    logic [WORD_W-1:0] data;
  } recv_entry_t;

endpackage

//--- cpu_reset_gen.sv
`timescale 1ns/100ps

module cpu_reset_gen (
  input  logic CPU_CLK,
  input  logic RST,
  output logic cpu_rst_n
);
  import chip_pkg::*;

  logic [RST_CNT_W-1:0] rst_count;

  // the top bit doubles as the release flag and stops the count
  assign cpu_rst_n = rst_count[RST_CNT_W-1];

  always_ff @(posedge CPU_CLK) begin
    if (!RST) begin
      rst_count <= '0;
    end else if (!cpu_rst_n) begin
      rst_count <= rst_count + 1'b1;
    end
  end

endmodule

//--- lsab_fifo.sv
`timescale 1ns/100ps

module lsab_fifo #(
  parameter type payload_t = logic [chip_pkg::WORD_W-1:0]
) (
  input  logic     CPU_CLK,
  input  logic     cpu_rst_n,
  input  logic     push,
  input  payload_t push_data,
  input  logic     pop,
  output payload_t head_data,
  output logic     empty,
  output logic     full
);
  import chip_pkg::*;

  payload_t           mem [FIFO_DEPTH];
  logic [FIFO_AW-1:0] wr_ptr;
  logic [FIFO_AW-1:0] rd_ptr;
  logic [FIFO_AW:0]   count;

  assign empty = (count == '0);
  assign full = (count == (FIFO_AW + 1)'(FIFO_DEPTH));
  // show-ahead, the oldest entry is always on the output
  assign head_data = mem[rd_ptr];

  always_ff @(posedge CPU_CLK) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge CPU_CLK) begin
    if (!cpu_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // the owner gates its strobes, so these only fire on a broken caller
  a_no_push_full: assert property (@(posedge CPU_CLK) disable iff (!cpu_rst_n)
    !(push && full));
  a_no_pop_empty: assert property (@(posedge CPU_CLK) disable iff (!cpu_rst_n)
    !(pop && empty));

endmodule

//--- lsab_hub.sv
`timescale 1ns/100ps

module lsab_hub (
  input  logic                       CPU_CLK,
  input  logic                       cpu_rst_n,
  input  logic                       host_send_valid,
  input  logic [chip_pkg::WORD_W-1:0] host_send_data,
  output logic                       host_send_full,
  input  logic                       host_recv_pop,
  output logic [chip_pkg::WORD_W-1:0] host_recv_data,
  output logic [chip_pkg::ANC_W-1:0]  host_recv_anc,
  output logic                       host_recv_empty,
  output logic                       host_irq,
  input  logic                       host_irq_ack,
  output logic                       host_err,
  input  logic                       host_err_ack,
  output logic                       send_ready,
  output logic [chip_pkg::WORD_W-1:0] send_data,
  input  logic                       link_read,
  input  logic                       link_write,
  input  logic [chip_pkg::WORD_W-1:0] recv_data,
  input  logic [chip_pkg::ANC_W-1:0]  recv_anc,
  input  logic                       link_irq,
  input  logic                       link_collision,
  output logic                       link_collision_ack
);
  import chip_pkg::*;

  logic        send_push;
  logic        send_pop;
  logic        send_empty;
  logic        recv_push;
  logic        recv_pop;
  logic        recv_full;
  recv_entry_t recv_in;
  recv_entry_t recv_head;

  // a strobe that meets a full FIFO is simply dropped
  assign send_push = host_send_valid && !host_send_full;
  assign send_pop = link_read && !send_empty;
  assign send_ready = !send_empty;

  lsab_fifo #(.payload_t(logic [WORD_W-1:0])) u_send_fifo (
    .CPU_CLK   (CPU_CLK),
    .cpu_rst_n (cpu_rst_n),
    .push      (send_push),
    .push_data (host_send_data),
    .pop       (send_pop),
    .head_data (send_data),
    .empty     (send_empty),
    .full      (host_send_full)
  );

  assign recv_in = '{anc: recv_anc, data: recv_data};
  assign recv_push = link_write && !recv_full;
  assign recv_pop = host_recv_pop && !host_recv_empty;
  assign host_recv_data = recv_head.data;
  assign host_recv_anc = recv_head.anc;

  lsab_fifo #(.payload_t(recv_entry_t)) u_recv_fifo (
    .CPU_CLK   (CPU_CLK),
    .cpu_rst_n (cpu_rst_n),
    .push      (recv_push),
    .push_data (recv_in),
    .pop       (recv_pop),
    .head_data (recv_head),
    .empty     (host_recv_empty),
    .full      (recv_full)
  );

  // a new bad frame beats an acknowledge in the same cycle
  always_ff @(posedge CPU_CLK) begin
    if (!cpu_rst_n) begin
      host_irq <= 1'b0;
    end else if (link_irq) begin
      host_irq <= 1'b1;
    end else if (host_irq_ack) begin
      host_irq <= 1'b0;
    end
  end

  assign host_err = link_collision;
  assign link_collision_ack = host_err_ack;

endmodule

//--- wire_link.sv
`timescale 1ns/100ps

module wire_link (
  input  logic                       CPU_CLK,
  input  logic                       cpu_rst_n,
  input  logic                       wire_rx,
  output logic                       wire_tx,
  input  logic                       send_ready,
  input  logic [chip_pkg::WORD_W-1:0] send_data,
  output logic                       link_read,
  output logic                       link_write,
  output logic [chip_pkg::WORD_W-1:0] recv_data,
  output logic [chip_pkg::ANC_W-1:0]  recv_anc,
  output logic                       link_irq,
  output logic                       link_collision,
  input  logic                       link_collision_ack
);
  import chip_pkg::*;

  typedef enum logic {TX_IDLE, TX_FRAME} tx_state_t;
  typedef enum logic {RX_IDLE, RX_FRAME} rx_state_t;

  tx_state_t             tx_state;
  logic [BIT_CW-1:0]     tx_cyc;
  logic [IDX_W-1:0]      tx_idx;
  logic [FRAME_BITS-1:0] tx_frame;
  logic                  tx_start;
  logic                  tx_bit_end;
  logic                  tx_mismatch;

  rx_state_t             rx_state;
  logic                  rx_meta;
  logic                  rx_sync;
  logic                  rx_prev;
  logic [BIT_CW-1:0]     rx_cyc;
  logic [IDX_W-1:0]      rx_idx;
  logic                  rx_par;
  logic                  rx_sample;
  logic [WORD_W-1:0]     rx_shift;
  recv_entry_t           rx_entry;

  assign tx_start = (tx_state == TX_IDLE) && send_ready && !link_collision;
  assign link_read = tx_start;
  assign tx_bit_end = (tx_cyc == BIT_CW'(BIT_CYCLES - 1));
  // rx_sync lags wire_tx by two cycles, so mid-bit it shows the bit now on the line
  assign tx_mismatch = (tx_state == TX_FRAME) && (tx_cyc == BIT_CW'(TX_CHECK_CYC)) &&
                       (rx_sync != tx_frame[0]);
  assign wire_tx = (tx_state == TX_FRAME) ? tx_frame[0] : 1'b1;

  always_ff @(posedge CPU_CLK) begin
    if (!cpu_rst_n) begin
      tx_state <= TX_IDLE;
      tx_cyc <= '0;
      tx_idx <= '0;
    end else if (tx_start) begin
      tx_state <= TX_FRAME;
      tx_cyc <= '0;
      tx_idx <= '0;
    end else if (tx_state == TX_FRAME) begin
      tx_cyc <= tx_bit_end ? '0 : tx_cyc + 1'b1;
      if (tx_mismatch) begin
        tx_state <= TX_IDLE;
      end else if (tx_bit_end) begin
        tx_idx <= tx_idx + 1'b1;
        if (tx_idx == IDX_W'(FRAME_BITS - 1)) begin
          tx_state <= TX_IDLE;
        end
      end
    end
  end

  // frame bit 0 is the start bit, shifted out first
  always_ff @(posedge CPU_CLK) begin
    if (tx_start) begin
      tx_frame <= {1'b1, ^send_data, send_data, 1'b0};
    end else if (tx_state == TX_FRAME && tx_bit_end) begin
      tx_frame <= {1'b1, tx_frame[FRAME_BITS-1:1]};
    end
  end

  always_ff @(posedge CPU_CLK) begin
    if (!cpu_rst_n) begin
      link_collision <= 1'b0;
    end else if (tx_mismatch) begin
      link_collision <= 1'b1;
    end else if (link_collision_ack) begin
      link_collision <= 1'b0;
    end
  end

  always_ff @(posedge CPU_CLK) begin
    if (!cpu_rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= wire_rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  assign rx_sample = (rx_state == RX_FRAME) && (rx_cyc == BIT_CW'(RX_SAMPLE_CYC));

  always_ff @(posedge CPU_CLK) begin
    if (!cpu_rst_n) begin
      rx_state <= RX_IDLE;
      rx_cyc <= '0;
      rx_idx <= '0;
      rx_par <= 1'b0;
      link_write <= 1'b0;
      link_irq <= 1'b0;
    end else begin
      link_write <= 1'b0;
      link_irq <= 1'b0;
      if (rx_state == RX_IDLE) begin
        rx_cyc <= '0;
        rx_idx <= '0;
        rx_par <= 1'b0;
        if (rx_prev && !rx_sync) begin
          rx_state <= RX_FRAME;
        end
      end else begin
        rx_cyc <= (rx_cyc == BIT_CW'(BIT_CYCLES - 1)) ? '0 : rx_cyc + 1'b1;
        if (rx_sample) begin
          rx_idx <= rx_idx + 1'b1;
          if (rx_idx == '0) begin
            // start bit gone high by mid-bit was only a glitch
            if (rx_sync) begin
              rx_state <= RX_IDLE;
            end
          end else if (rx_idx == IDX_W'(FRAME_BITS - 1)) begin
            link_write <= 1'b1;
            link_irq <= rx_par || !rx_sync;
            rx_state <= RX_IDLE;
          end else begin
            rx_par <= rx_par ^ rx_sync;
          end
        end
      end
    end
  end

  always_ff @(posedge CPU_CLK) begin
    if (rx_sample && rx_idx >= IDX_W'(1) && rx_idx <= IDX_W'(WORD_W)) begin
      rx_shift <= {rx_sync, rx_shift[WORD_W-1:1]};
    end
    if (rx_sample && rx_idx == IDX_W'(FRAME_BITS - 1)) begin
      rx_entry.data <= rx_shift;
      rx_entry.anc <= {rx_sync, !rx_par};
    end
  end

  assign recv_data = rx_entry.data;
  assign recv_anc = rx_entry.anc;

  a_no_start_in_collision: assert property (@(posedge CPU_CLK) disable iff (!cpu_rst_n)
    (tx_state == TX_IDLE && link_collision) |=> (tx_state == TX_IDLE));

endmodule

//--- chip.sv
`timescale 1ns/100ps

module chip (
  input  logic                       CPU_CLK,
  input  logic                       RST,
  input  logic                       wire_rx,
  output logic                       wire_tx,
  input  logic                       host_send_valid,
  input  logic [chip_pkg::WORD_W-1:0] host_send_data,
  output logic                       host_send_full,
  input  logic                       host_recv_pop,
  output logic [chip_pkg::WORD_W-1:0] host_recv_data,
  output logic [chip_pkg::ANC_W-1:0]  host_recv_anc,
  output logic                       host_recv_empty,
  output logic                       host_irq,
  input  logic                       host_irq_ack,
  output logic                       host_err,
  input  logic                       host_err_ack
);
  import chip_pkg::*;

  logic              cpu_rst_n;
  logic              send_ready;
  logic [WORD_W-1:0] send_data;
  logic              link_read;
  logic              link_write;
  logic [WORD_W-1:0] recv_data;
  logic [ANC_W-1:0]  recv_anc;
  logic              link_irq;
  logic              link_collision;
  logic              link_collision_ack;

  cpu_reset_gen u_reset_gen (
    .CPU_CLK   (CPU_CLK),
    .RST       (RST),
    .cpu_rst_n (cpu_rst_n)
  );

  lsab_hub u_hub (
    .CPU_CLK            (CPU_CLK),
    .cpu_rst_n          (cpu_rst_n),
    .host_send_valid    (host_send_valid),
    .host_send_data     (host_send_data),
    .host_send_full     (host_send_full),
    .host_recv_pop      (host_recv_pop),
    .host_recv_data     (host_recv_data),
    .host_recv_anc      (host_recv_anc),
    .host_recv_empty    (host_recv_empty),
    .host_irq           (host_irq),
    .host_irq_ack       (host_irq_ack),
    .host_err           (host_err),
    .host_err_ack       (host_err_ack),
    .send_ready         (send_ready),
    .send_data          (send_data),
    .link_read          (link_read),
    .link_write         (link_write),
    .recv_data          (recv_data),
    .recv_anc           (recv_anc),
    .link_irq           (link_irq),
    .link_collision     (link_collision),
    .link_collision_ack (link_collision_ack)
  );

  wire_link u_link (
    .CPU_CLK            (CPU_CLK),
    .cpu_rst_n          (cpu_rst_n),
    .wire_rx            (wire_rx),
    .wire_tx            (wire_tx),
    .send_ready         (send_ready),
    .send_data          (send_data),
    .link_read          (link_read),
    .link_write         (link_write),
    .recv_data          (recv_data),
    .recv_anc           (recv_anc),
    .link_irq           (link_irq),
    .link_collision     (link_collision),
    .link_collision_ack (link_collision_ack)
  );

endmodule

//--- tb_chip.sv
`timescale 1ns/100ps

module tb_chip;
  import chip_pkg::*;

  localparam int FRAME_CYC = FRAME_BITS * BIT_CYCLES;
  // one frame out and one frame of slack for the receive path
  localparam int FRAME_WAIT = 2 * FRAME_CYC + 40;

  logic              CPU_CLK;
  logic              RST;
  logic              wire_rx;
  logic              wire_tx;
  logic              host_send_valid;
  logic [WORD_W-1:0] host_send_data;
  logic              host_send_full;
  logic              host_recv_pop;
  logic [WORD_W-1:0] host_recv_data;
  logic [ANC_W-1:0]  host_recv_anc;
  logic              host_recv_empty;
  logic              host_irq;
  logic              host_irq_ack;
  logic              host_err;
  logic              host_err_ack;

  logic              use_tb_line;
  logic              tb_line;
  logic [31:0]       lfsr_state;
  int                mismatch_count;
  int                other_count;
  string             cur_test;
  recv_entry_t       exp_q[$];
  recv_entry_t       cmp_entry;
  recv_entry_t       bad_entry;
  logic [WORD_W-1:0] sent_q[$];
  logic [WORD_W-1:0] word;
  int                drops;
  int                tx_low;

  // loopback unless the testbench takes over the line
  assign wire_rx = use_tb_line ? tb_line : wire_tx;

  chip u_dut (
    .CPU_CLK         (CPU_CLK),
    .RST             (RST),
    .wire_rx         (wire_rx),
    .wire_tx         (wire_tx),
    .host_send_valid (host_send_valid),
    .host_send_data  (host_send_data),
    .host_send_full  (host_send_full),
    .host_recv_pop   (host_recv_pop),
    .host_recv_data  (host_recv_data),
    .host_recv_anc   (host_recv_anc),
    .host_recv_empty (host_recv_empty),
    .host_irq        (host_irq),
    .host_irq_ack    (host_irq_ack),
    .host_err        (host_err),
    .host_err_ack    (host_err_ack)
  );

  initial begin
    CPU_CLK = 1'b0;
  end

  always #20 CPU_CLK = ~CPU_CLK;

  // galois form with taps 32 30 26 25 and one step per bit taken
  function automatic logic [31:0] rand_word();
    logic [31:0] w;
    logic        b;
    w = '0;
    for (int i = 0; i < 32; i++) begin
      b = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (b) begin
        lfsr_state = lfsr_state ^ 32'ha300_0000;
      end
      w = {w[30:0], b};
    end
    return w;
  endfunction

  // a clean frame arrives with both parity and stop flags good
  function automatic recv_entry_t expected_entry(input logic [WORD_W-1:0] w);
    recv_entry_t e;
    e.data = w;
    e.anc = 2'b11;
    return e;
  endfunction

  task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      $display("Fail %s %s: expected %h, actual %h", cur_test, name, exp, act);
      mismatch_count++;
    end
  endtask

  task automatic report_error(input string what);
    $display("Error in %s: %s", cur_test, what);
    other_count++;
  endtask

  task automatic step();
    @(posedge CPU_CLK);
    #2;
  endtask

  task automatic push_word(input logic [WORD_W-1:0] w);
    host_send_valid = 1'b1;
    host_send_data = w;
    step();
    host_send_valid = 1'b0;
  endtask

  task automatic wait_send_space();
    int n;
    n = 0;
    while (host_send_full && n < FRAME_WAIT) begin
      step();
      n++;
    end
    if (host_send_full) begin
      report_error("send FIFO never had room");
    end
  endtask

  task automatic wait_recv();
    int n;
    n = 0;
    while (host_recv_empty && n < FRAME_WAIT) begin
      step();
      n++;
    end
    if (host_recv_empty) begin
      report_error("no entry arrived on the receive side");
    end
  endtask

  task automatic pop_entry();
    wait_recv();
    if (!host_recv_empty) begin
      host_recv_pop = 1'b1;
      step();
      host_recv_pop = 1'b0;
    end
  endtask

  task automatic wait_err();
    int n;
    n = 0;
    while (!host_err && n < 4 * FRAME_CYC) begin
      step();
      n++;
    end
    if (!host_err) begin
      report_error("collision error never rose");
    end
  endtask

  // the send side is done once the line has been high for a whole frame
  task automatic wait_quiet();
    int n;
    int quiet;
    n = 0;
    quiet = 0;
    while (quiet < FRAME_CYC && n < 12 * FRAME_CYC) begin
      step();
      quiet = wire_tx ? quiet + 1 : 0;
      n++;
    end
    if (quiet < FRAME_CYC) begin
      report_error("serial line never went quiet");
    end
  endtask

  task automatic drive_frame(input logic [WORD_W-1:0] w, input logic par, input logic stop);
    logic [FRAME_BITS-1:0] bits;
    bits = {stop, par, w, 1'b0};
    for (int i = 0; i < FRAME_BITS; i++) begin
      tb_line = bits[i];
      repeat (BIT_CYCLES) step();
    end
    tb_line = 1'b1;
    repeat (2 * BIT_CYCLES) step();
  endtask

  // every accepted pop is checked against the oldest expected entry
  always @(posedge CPU_CLK) begin
    if (host_recv_pop && !host_recv_empty) begin
      if (exp_q.size() == 0) begin
        report_error("an entry was popped that was never expected");
      end else begin
        cmp_entry = exp_q.pop_front();
        check("recv data", cmp_entry.data, host_recv_data);
        check("recv anc", cmp_entry.anc, host_recv_anc);
      end
    end
  end

  initial begin
    lfsr_state = 32'hfa2b_7151;
    mismatch_count = 0;
    other_count = 0;
    RST = 1'b0;
    host_send_valid = 1'b0;
    host_send_data = '0;
    host_recv_pop = 1'b0;
    host_irq_ack = 1'b0;
    host_err_ack = 1'b0;
    use_tb_line = 1'b0;
    tb_line = 1'b1;

    cur_test = "reset";
    repeat (8) step();
    RST = 1'b1;
    check("wire_tx idle", 1, wire_tx);
    check("recv empty", 1, host_recv_empty);
    check("send full", 0, host_send_full);
    check("irq", 0, host_irq);
    check("err", 0, host_err);
    // the core comes out of reset 2**(RST_CNT_W-1) cycles after RST
    repeat (1 << (RST_CNT_W - 1)) step();
    word = rand_word();
    push_word(word);
    exp_q.push_back(expected_entry(word));
    pop_entry();

    cur_test = "loopback";
    for (int i = 0; i < 10; i++) begin
      word = rand_word();
      push_word(word);
      exp_q.push_back(expected_entry(word));
      pop_entry();
      check("irq stays low", 0, host_irq);
    end

    cur_test = "send back-pressure";
    tb_line = 1'b1;
    use_tb_line = 1'b1;
    drops = 0;
    while (!host_send_full && drops < 4 * FIFO_DEPTH) begin
      word = rand_word();
      push_word(word);
      sent_q.push_back(word);
      drops++;
    end
    // the first word leaves the FIFO when its frame starts
    check("pushes until full", FIFO_DEPTH + 1, sent_q.size());
    repeat (3) push_word(rand_word());
    wait_err();
    check("nothing received", 1, host_recv_empty);
    use_tb_line = 1'b0;
    step();
    host_err_ack = 1'b1;
    step();
    host_err_ack = 1'b0;
    // the word in flight was lost to the collision
    void'(sent_q.pop_front());
    foreach (sent_q[i]) begin
      exp_q.push_back(expected_entry(sent_q[i]));
    end
    foreach (sent_q[i]) begin
      pop_entry();
    end
    wait_quiet();
    check("no extra entry", 1, host_recv_empty);
    sent_q.delete();

    cur_test = "collision";
    tb_line = 1'b1;
    use_tb_line = 1'b1;
    push_word(rand_word());
    wait_err();
    drops = 0;
    tx_low = 0;
    repeat (100) begin
      step();
      if (!host_err) begin
        drops++;
      end
      if (!wire_tx) begin
        tx_low++;
      end
    end
    check("err held", 0, drops);
    check("line idle after abort", 0, tx_low);
    check("no entry", 1, host_recv_empty);
    host_err_ack = 1'b1;
    step();
    host_err_ack = 1'b0;
    check("err cleared", 0, host_err);
    use_tb_line = 1'b0;
    word = rand_word();
    push_word(word);
    exp_q.push_back(expected_entry(word));
    pop_entry();
    check("err after resend", 0, host_err);

    cur_test = "bad frame";
    tb_line = 1'b1;
    use_tb_line = 1'b1;
    repeat (2 * BIT_CYCLES) step();
    word = rand_word();
    bad_entry = expected_entry(word);
    bad_entry.anc[0] = 1'b0;
    exp_q.push_back(bad_entry);
    drive_frame(word, ~^word, 1'b1);
    wait_recv();
    check("irq on parity", 1, host_irq);
    pop_entry();
    host_irq_ack = 1'b1;
    step();
    host_irq_ack = 1'b0;
    check("irq cleared", 0, host_irq);
    word = rand_word();
    bad_entry = expected_entry(word);
    bad_entry.anc[1] = 1'b0;
    exp_q.push_back(bad_entry);
    drive_frame(word, ^word, 1'b0);
    wait_recv();
    check("irq on stop", 1, host_irq);
    pop_entry();
    host_irq_ack = 1'b1;
    step();
    host_irq_ack = 1'b0;
    check("irq cleared", 0, host_irq);
    use_tb_line = 1'b0;

    cur_test = "receive overflow";
    for (int i = 0; i < FIFO_DEPTH + 1; i++) begin
      word = rand_word();
      wait_send_space();
      push_word(word);
      if (i < FIFO_DEPTH) begin
        exp_q.push_back(expected_entry(word));
      end
    end
    wait_quiet();
    repeat (FIFO_DEPTH) pop_entry();
    check("recv empty after drain", 1, host_recv_empty);

    if (exp_q.size() != 0) begin
      report_error("some expected entries never arrived");
    end
    $display("test done: %0d value mismatches, %0d other failures",
             mismatch_count, other_count);
    if (mismatch_count + other_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- flist.f
chip_pkg.sv
cpu_reset_gen.sv
lsab_fifo.sv
lsab_hub.sv
wire_link.sv
chip.sv
tb_chip.sv
